// File: include/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// PC given to the first instruction accepted after reset.
`define RV_RESET_PC 32'h0000_0000

// Architectural register count.
`define RV_NUM_REGS 32

// Word address bits driven on the data bus.
`define RV_MEM_ADDR_WIDTH 10

`endif

// File: hdl/rv_core_pkg.sv
package rv_core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [6:0]  opcode_t;

   // Major opcodes of the supported RV32I subset.
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011;
   localparam opcode_t OPC_LUI    = 7'b0110111;
   localparam opcode_t OPC_AUIPC  = 7'b0010111;
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_STORE  = 7'b0100011;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_LOAD,
      MEM_STORE
   } mem_op_e;

   typedef enum logic {
      RES_IDLE,
      RES_BUS
   } result_state_e;

endpackage

// File: hdl/rv_stage_if.sv
`timescale 1ns/1ps

interface rv_stage_if;
   import rv_core_pkg::*;

   logic      valid;
   logic      ready;
   alu_op_e   alu_op;
   mem_op_e   mem_op;
   reg_addr_t rd;
   // Between execute and result this carries the ALU result or the address.
   word_t     operand_a;
   word_t     operand_b;
   word_t     store_data;

   modport sender (
      output valid,
      output alu_op,
      output mem_op,
      output rd,
      output operand_a,
      output operand_b,
      output store_data,
      input  ready
   );

   modport receiver (
      input  valid,
      input  alu_op,
      input  mem_op,
      input  rd,
      input  operand_a,
      input  operand_b,
      input  store_data,
      output ready
   );

endinterface

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_regfile (
   input  logic                  clk,
   input  logic                  reset,
   input  rv_core_pkg::reg_addr_t raddr_a_i,
   input  rv_core_pkg::reg_addr_t raddr_b_i,
   output rv_core_pkg::word_t     rdata_a_o,
   output rv_core_pkg::word_t     rdata_b_o,
   input  logic                  we_i,
   input  rv_core_pkg::reg_addr_t waddr_i,
   input  rv_core_pkg::word_t     wdata_i
);
   import rv_core_pkg::*;

   word_t regs [`RV_NUM_REGS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && (waddr_i != '0)) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   // x0 is hardwired to zero regardless of what the array holds.
   assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
   assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: hdl/rv_decode.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_decode (
   input  logic                  clk,
   input  logic                  reset,
   input  rv_core_pkg::word_t     insn_i,
   input  logic                  insn_valid_i,
   output logic                  insn_ready_o,
   input  logic                  wb_we_i,
   input  rv_core_pkg::reg_addr_t wb_rd_i,
   input  rv_core_pkg::word_t     wb_data_i,
   rv_stage_if.sender            out
);
   import rv_core_pkg::*;

   logic                    need_rs1;
   logic                    need_rs2;
   logic                    need_rd;
   reg_addr_t               dst_in;
   logic                    hazard;
   logic                    accept;
   logic                    advance;
   logic                    ready_en;
   logic [`RV_NUM_REGS-1:0] busy;
   word_t                   pc;
   logic                    insn_q_valid;
   word_t                   insn_q;
   word_t                   pc_q;
   reg_addr_t               dst_q;
   word_t                   rdata_a;
   word_t                   rdata_b;
   word_t                   imm;
   word_t                   op_a;
   word_t                   op_b;
   alu_op_e                 alu_op;
   mem_op_e                 mem_op;
   logic                    sel_pc;
   logic                    zero_a;
   logic                    sel_imm;

   function automatic alu_op_e alu_func(input logic [2:0] funct3, input logic alt);
      case (funct3)
         3'b000:  return alt ? ALU_SUB : ALU_ADD;
         3'b001:  return ALU_SLL;
         3'b010:  return ALU_SLT;
         3'b011:  return ALU_SLTU;
         3'b100:  return ALU_XOR;
         3'b101:  return alt ? ALU_SRA : ALU_SRL;
         3'b110:  return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   // Register usage of the presented instruction, for the scoreboard check.
   always_comb begin
      need_rs1 = 1'b0;
      need_rs2 = 1'b0;
      need_rd  = 1'b0;
      case (opcode_t'(insn_i[6:0]))
         OPC_OP: begin
            need_rs1 = 1'b1;
            need_rs2 = 1'b1;
            need_rd  = 1'b1;
         end
         OPC_OP_IMM, OPC_LOAD: begin
            need_rs1 = 1'b1;
            need_rd  = 1'b1;
         end
         OPC_LUI, OPC_AUIPC: need_rd = 1'b1;
         OPC_STORE: begin
            need_rs1 = 1'b1;
            need_rs2 = 1'b1;
         end
         default: ;
      endcase
   end

   assign dst_in = need_rd ? insn_i[11:7] : '0;
   assign hazard = (need_rs1 && busy[insn_i[19:15]]) ||
                   (need_rs2 && busy[insn_i[24:20]]) || busy[dst_in];
   assign advance = insn_q_valid && (!out.valid || out.ready);
   assign insn_ready_o = ready_en && !hazard && (!insn_q_valid || advance);
   assign accept = insn_valid_i && insn_ready_o;

   always_ff @(posedge clk) begin
      if (reset) begin
         ready_en     <= 1'b0;
         pc           <= `RV_RESET_PC;
         insn_q_valid <= 1'b0;
         busy         <= '0;
         out.valid    <= 1'b0;
      end else begin
         ready_en <= 1'b1;
         if (accept) begin
            pc <= pc + 32'd4;
         end
         if (accept) begin
            insn_q_valid <= 1'b1;
         end else if (advance) begin
            insn_q_valid <= 1'b0;
         end
         if (wb_we_i) begin
            busy[wb_rd_i] <= 1'b0;
         end
         // x0 is never marked, so writes to it never stall anything.
         if (accept && (dst_in != '0)) begin
            busy[dst_in] <= 1'b1;
         end
         if (advance) begin
            out.valid <= 1'b1;
         end else if (out.ready) begin
            out.valid <= 1'b0;
         end
      end
   end

   rv_regfile rv_regfile_inst (
      .clk       (clk),
      .reset     (reset),
      .raddr_a_i (insn_q[19:15]),
      .raddr_b_i (insn_q[24:20]),
      .rdata_a_o (rdata_a),
      .rdata_b_o (rdata_b),
      .we_i      (wb_we_i),
      .waddr_i   (wb_rd_i),
      .wdata_i   (wb_data_i)
   );

   // Unknown opcodes fall through as an add whose destination is x0.
   always_comb begin
      alu_op  = ALU_ADD;
      mem_op  = MEM_NONE;
      imm     = {{20{insn_q[31]}}, insn_q[31:20]};
      sel_pc  = 1'b0;
      zero_a  = 1'b0;
      sel_imm = 1'b1;
      case (opcode_t'(insn_q[6:0]))
         OPC_OP: begin
            sel_imm = 1'b0;
            alu_op  = alu_func(insn_q[14:12], insn_q[30]);
         end
         OPC_OP_IMM: alu_op = alu_func(insn_q[14:12], insn_q[30] && (insn_q[14:12] == 3'b101));
         OPC_LUI: begin
            imm    = {insn_q[31:12], 12'h000};
            zero_a = 1'b1;
            alu_op = ALU_PASS_B;
         end
         OPC_AUIPC: begin
            imm    = {insn_q[31:12], 12'h000};
            sel_pc = 1'b1;
         end
         OPC_LOAD: mem_op = MEM_LOAD;
         OPC_STORE: begin
            imm    = {{20{insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
            mem_op = MEM_STORE;
         end
         default: ;
      endcase
      op_a = zero_a ? '0 : (sel_pc ? pc_q : rdata_a);
      op_b = sel_imm ? imm : rdata_b;
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         insn_q <= insn_i;
         pc_q   <= pc;
         dst_q  <= dst_in;
      end
      if (advance) begin
         out.alu_op     <= alu_op;
         out.mem_op     <= mem_op;
         out.rd         <= dst_q;
         out.operand_a  <= op_a;
         out.operand_b  <= op_b;
         out.store_data <= rdata_b;
      end
   end

endmodule

// File: hdl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
   input  logic         clk,
   input  logic         reset,
   rv_stage_if.receiver in,
   rv_stage_if.sender   out
);
   import rv_core_pkg::*;

   word_t      result;
   word_t      sum;
   logic [4:0] shamt;
   logic       take;

   // The output register can accept when empty or when it drains this cycle.
   assign in.ready = !out.valid || out.ready;
   assign take     = in.valid && in.ready;

   // Loads and stores use the adder output as their byte address.
   assign sum   = in.operand_a + in.operand_b;
   assign shamt = in.operand_b[4:0];

   always_comb begin
      case (in.alu_op)
         ALU_ADD:    result = sum;
         ALU_SUB:    result = in.operand_a - in.operand_b;
         ALU_AND:    result = in.operand_a & in.operand_b;
         ALU_OR:     result = in.operand_a | in.operand_b;
         ALU_XOR:    result = in.operand_a ^ in.operand_b;
         ALU_SLT:    result = {31'd0, $signed(in.operand_a) < $signed(in.operand_b)};
         ALU_SLTU:   result = {31'd0, in.operand_a < in.operand_b};
         ALU_SLL:    result = in.operand_a << shamt;
         ALU_SRL:    result = in.operand_a >> shamt;
         ALU_SRA:    result = word_t'($signed(in.operand_a) >>> shamt);
         ALU_PASS_B: result = in.operand_b;
         default:    result = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out.valid <= 1'b0;
      end else if (take) begin
         out.valid <= 1'b1;
      end else if (out.ready) begin
         out.valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         out.alu_op     <= in.alu_op;
         out.mem_op     <= in.mem_op;
         out.rd         <= in.rd;
         out.operand_a  <= result;
         out.operand_b  <= in.operand_b;
         out.store_data <= in.store_data;
      end
   end

endmodule

// File: hdl/rv_result.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_result (
   input  logic                          clk,
   input  logic                          reset,
   rv_stage_if.receiver                  in,
   output logic                          wb_cyc_o,
   output logic                          wb_stb_o,
   output logic                          wb_we_o,
   output logic [`RV_MEM_ADDR_WIDTH-1:0] wb_adr_o,
   output rv_core_pkg::word_t             wb_dat_o,
   input  rv_core_pkg::word_t             wb_dat_i,
   input  logic                          wb_ack_i,
   output logic                          retire_valid_o,
   output rv_core_pkg::reg_addr_t         retire_rd_o,
   output rv_core_pkg::word_t             retire_data_o
);
   import rv_core_pkg::*;

   result_state_e state;
   logic          take;

   assign in.ready = (state == RES_IDLE);
   assign take     = in.valid && in.ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= RES_IDLE;
         wb_cyc_o       <= 1'b0;
         wb_stb_o       <= 1'b0;
         wb_we_o        <= 1'b0;
         wb_adr_o       <= '0;
         wb_dat_o       <= '0;
         retire_valid_o <= 1'b0;
         retire_rd_o    <= '0;
         retire_data_o  <= '0;
      end else begin
         retire_valid_o <= 1'b0;
         case (state)
            RES_IDLE: begin
               if (take) begin
                  // The destination is kept here so a load can retire on its ack.
                  retire_rd_o <= in.rd;
                  if (in.mem_op == MEM_NONE) begin
                     retire_data_o  <= in.operand_a;
                     retire_valid_o <= (in.rd != '0);
                  end else begin
                     state    <= RES_BUS;
                     wb_cyc_o <= 1'b1;
                     wb_stb_o <= 1'b1;
                     wb_we_o  <= (in.mem_op == MEM_STORE);
                     wb_adr_o <= in.operand_a[`RV_MEM_ADDR_WIDTH+1:2];
                     wb_dat_o <= in.store_data;
                  end
               end
            end
            RES_BUS: begin
               // All bus fields hold until the slave acknowledges.
               if (wb_ack_i) begin
                  state    <= RES_IDLE;
                  wb_cyc_o <= 1'b0;
                  wb_stb_o <= 1'b0;
                  wb_we_o  <= 1'b0;
                  if (!wb_we_o) begin
                     retire_data_o  <= wb_dat_i;
                     retire_valid_o <= (retire_rd_o != '0);
                  end
               end
            end
            default: state <= RES_IDLE;
         endcase
      end
   end

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_core_top (
   input  logic                          clk,
   input  logic                          reset,
   input  rv_core_pkg::word_t             insn_i,
   input  logic                          insn_valid_i,
   output logic                          insn_ready_o,
   output logic                          wb_cyc_o,
   output logic                          wb_stb_o,
   output logic                          wb_we_o,
   output logic [`RV_MEM_ADDR_WIDTH-1:0] wb_adr_o,
   output rv_core_pkg::word_t             wb_dat_o,
   input  rv_core_pkg::word_t             wb_dat_i,
   input  logic                          wb_ack_i,
   output logic                          retire_valid_o,
   output rv_core_pkg::reg_addr_t         retire_rd_o,
   output rv_core_pkg::word_t             retire_data_o
);

   rv_stage_if dec_exe_if ();
   rv_stage_if exe_res_if ();

   // Write-back comes from the retire port, which also clears the scoreboard.
   rv_decode rv_decode_inst (
      .clk          (clk),
      .reset        (reset),
      .insn_i       (insn_i),
      .insn_valid_i (insn_valid_i),
      .insn_ready_o (insn_ready_o),
      .wb_we_i      (retire_valid_o),
      .wb_rd_i      (retire_rd_o),
      .wb_data_i    (retire_data_o),
      .out          (dec_exe_if.sender)
   );

   rv_execute rv_execute_inst (
      .clk   (clk),
      .reset (reset),
      .in    (dec_exe_if.receiver),
      .out   (exe_res_if.sender)
   );

   rv_result rv_result_inst (
      .clk            (clk),
      .reset          (reset),
      .in             (exe_res_if.receiver),
      .wb_cyc_o       (wb_cyc_o),
      .wb_stb_o       (wb_stb_o),
      .wb_we_o        (wb_we_o),
      .wb_adr_o       (wb_adr_o),
      .wb_dat_o       (wb_dat_o),
      .wb_dat_i       (wb_dat_i),
      .wb_ack_i       (wb_ack_i),
      .retire_valid_o (retire_valid_o),
      .retire_rd_o    (retire_rd_o),
      .retire_data_o  (retire_data_o)
   );

endmodule

// File: testbench/rv_core_sva.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_core_sva (
   input logic                          clk,
   input logic                          reset,
   input logic                          insn_ready_o,
   input logic                          wb_cyc_o,
   input logic                          wb_stb_o,
   input logic                          wb_we_o,
   input logic [`RV_MEM_ADDR_WIDTH-1:0] wb_adr_o,
   input rv_core_pkg::word_t             wb_dat_o,
   input logic                          wb_ack_i,
   input logic                          retire_valid_o,
   input rv_core_pkg::reg_addr_t         retire_rd_o,
   input rv_core_pkg::word_t             retire_data_o
);

   int fail_count = 0;

   stb_within_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb_o |-> wb_cyc_o)
      else begin
         fail_count++;
         $error("wb_stb_o is high while wb_cyc_o is low");
      end

   // A request holds until the slave acknowledges it.
   bus_fields_hold: assert property (@(posedge clk) disable iff (reset)
      (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_we_o) && $stable(wb_adr_o) &&
                                   $stable(wb_dat_o)))
      else begin
         fail_count++;
         $error("Bus request changed before its ack");
      end

   retire_not_x0: assert property (@(posedge clk) disable iff (reset)
      retire_valid_o |-> (retire_rd_o != '0))
      else begin
         fail_count++;
         $error("Retire reported for x0");
      end

   outputs_known: assert property (@(posedge clk) disable iff (reset)
      !$isunknown({insn_ready_o, wb_cyc_o, wb_stb_o, wb_we_o, wb_adr_o, wb_dat_o,
                   retire_valid_o, retire_rd_o, retire_data_o}))
      else begin
         fail_count++;
         $error("An output of the core is unknown");
      end

   // Every reset edge leaves the handshake, bus and retire outputs low.
   outputs_low_in_reset: assert property (@(posedge clk)
      reset |=> !(insn_ready_o || wb_cyc_o || wb_stb_o || wb_we_o || retire_valid_o))
      else begin
         fail_count++;
         $error("An output of the core is high after a reset cycle");
      end

endmodule

bind rv_core_top rv_core_sva rv_core_sva_inst (.*);

// File: testbench/rv_core_checker.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_core_checker (
   input  logic                          clk,
   input  logic                          reset,
   input  rv_core_pkg::word_t             insn_i,
   input  logic                          insn_valid_i,
   input  logic                          insn_ready_o,
   input  logic                          wb_cyc_o,
   input  logic                          wb_stb_o,
   input  logic                          wb_we_o,
   input  logic [`RV_MEM_ADDR_WIDTH-1:0] wb_adr_o,
   input  rv_core_pkg::word_t             wb_dat_o,
   input  logic                          wb_ack_i,
   input  logic                          retire_valid_o,
   input  rv_core_pkg::reg_addr_t         retire_rd_o,
   input  rv_core_pkg::word_t             retire_data_o,
   output int                            error_count_o,
   output int                            pending_o,
   output int                            retire_count_o
);
   import rv_core_pkg::*;

   word_t                         model_regs [32];
   word_t                         model_mem [256];
   word_t                         model_pc;
   reg_addr_t                     exp_rd [$];
   word_t                         exp_data [$];
   logic [`RV_MEM_ADDR_WIDTH-1:0] exp_adr [$];
   word_t                         exp_wdat [$];

   // OP and OP-IMM arithmetic, where alt is instruction bit 30.
   function automatic word_t rv32i_alu(input logic [2:0] funct3, input logic alt,
                                       input word_t a, input word_t b);
      case (funct3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
         3'b011:  return {31'd0, a < b};
         3'b100:  return a ^ b;
         3'b101:  return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic model_step(input word_t insn);
      reg_addr_t rd;
      word_t     a;
      word_t     b;
      word_t     imm_i;
      word_t     addr;
      word_t     value;
      logic      writes;
      rd     = insn[11:7];
      a      = model_regs[insn[19:15]];
      b      = model_regs[insn[24:20]];
      imm_i  = {{20{insn[31]}}, insn[31:20]};
      writes = 1'b1;
      value  = '0;
      case (opcode_t'(insn[6:0]))
         OPC_OP:     value = rv32i_alu(insn[14:12], insn[30], a, b);
         OPC_OP_IMM: value = rv32i_alu(insn[14:12], insn[30] && (insn[14:12] == 3'b101), a, imm_i);
         OPC_LUI:    value = {insn[31:12], 12'h000};
         OPC_AUIPC:  value = model_pc + {insn[31:12], 12'h000};
         OPC_LOAD: begin
            addr  = a + imm_i;
            value = model_mem[addr[9:2]];
         end
         OPC_STORE: begin
            addr   = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
            writes = 1'b0;
            exp_adr.push_back(addr[`RV_MEM_ADDR_WIDTH+1:2]);
            exp_wdat.push_back(b);
            model_mem[addr[9:2]] = b;
         end
         default: writes = 1'b0;
      endcase
      if (writes && rd != '0) begin
         model_regs[rd] = value;
         exp_rd.push_back(rd);
         exp_data.push_back(value);
      end
      model_pc = model_pc + 32'd4;
   endtask

   task automatic check_retire();
      reg_addr_t rd;
      word_t     data;
      if (exp_rd.size() == 0) begin
         $display("ERROR: x%0d retired with no instruction outstanding", retire_rd_o);
         error_count_o++;
      end else begin
         rd   = exp_rd.pop_front();
         data = exp_data.pop_front();
         if (retire_rd_o !== rd) begin
            $display("FAIL retire_rd_o expected %h got %h", rd, retire_rd_o);
            error_count_o++;
         end
         if (retire_data_o !== data) begin
            $display("FAIL retire_data_o expected %h got %h", data, retire_data_o);
            error_count_o++;
         end
         retire_count_o++;
      end
   endtask

   task automatic check_write();
      logic [`RV_MEM_ADDR_WIDTH-1:0] adr;
      word_t                         data;
      if (exp_adr.size() == 0) begin
         $display("ERROR: bus write to word %h that no store asked for", wb_adr_o);
         error_count_o++;
      end else begin
         adr  = exp_adr.pop_front();
         data = exp_wdat.pop_front();
         if (wb_adr_o !== adr) begin
            $display("FAIL wb_adr_o expected %h got %h", adr, wb_adr_o);
            error_count_o++;
         end
         if (wb_dat_o !== data) begin
            $display("FAIL wb_dat_o expected %h got %h", data, wb_dat_o);
            error_count_o++;
         end
      end
   endtask

   // Everything is sampled mid-cycle, when the DUT outputs are settled.
   always @(negedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
         end
         for (int i = 0; i < 256; i++) begin
            model_mem[i] = '0;
         end
         model_pc = `RV_RESET_PC;
         exp_rd.delete();
         exp_data.delete();
         exp_adr.delete();
         exp_wdat.delete();
         error_count_o  = 0;
         retire_count_o = 0;
      end else begin
         if (insn_valid_i && insn_ready_o) begin
            model_step(insn_i);
         end
         if (retire_valid_o) begin
            check_retire();
         end
         if (wb_cyc_o && wb_stb_o && wb_we_o && wb_ack_i) begin
            check_write();
         end
      end
      pending_o = exp_rd.size() + exp_adr.size();
   end

endmodule

// File: testbench/rv_core_tb.sv
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_core_tb;
   import rv_core_pkg::*;

   localparam int NUM_INSNS     = 400;
   localparam int READY_TIMEOUT = 200;
   localparam int DRAIN_TIMEOUT = 2000;
   localparam int BUS_TIMEOUT   = 20;

   logic                          clk          = 1'b0;
   logic                          reset        = 1'b1;
   word_t                         insn_i       = '0;
   logic                          insn_valid_i = 1'b0;
   logic                          insn_ready_o;
   logic                          wb_cyc_o;
   logic                          wb_stb_o;
   logic                          wb_we_o;
   logic [`RV_MEM_ADDR_WIDTH-1:0] wb_adr_o;
   word_t                         wb_dat_o;
   word_t                         wb_dat_i     = '0;
   logic                          wb_ack_i     = 1'b0;
   logic                          retire_valid_o;
   reg_addr_t                     retire_rd_o;
   word_t                         retire_data_o;
   int                            checker_errors;
   int                            pending;
   int                            retired;
   word_t                         mem [256];
   logic                          mem_active    = 1'b0;
   int                            mem_delay     = 0;
   int                            bus_cycles    = 0;
   logic                          bus_timeout   = 1'b0;
   logic                          ready_timeout = 1'b0;

   initial begin
      forever #10 clk = ~clk;
   end

   rv_core_top rv_core_top_inst (
      .clk            (clk),
      .reset          (reset),
      .insn_i         (insn_i),
      .insn_valid_i   (insn_valid_i),
      .insn_ready_o   (insn_ready_o),
      .wb_cyc_o       (wb_cyc_o),
      .wb_stb_o       (wb_stb_o),
      .wb_we_o        (wb_we_o),
      .wb_adr_o       (wb_adr_o),
      .wb_dat_o       (wb_dat_o),
      .wb_dat_i       (wb_dat_i),
      .wb_ack_i       (wb_ack_i),
      .retire_valid_o (retire_valid_o),
      .retire_rd_o    (retire_rd_o),
      .retire_data_o  (retire_data_o)
   );

   rv_core_checker rv_core_checker_inst (
      .clk            (clk),
      .reset          (reset),
      .insn_i         (insn_i),
      .insn_valid_i   (insn_valid_i),
      .insn_ready_o   (insn_ready_o),
      .wb_cyc_o       (wb_cyc_o),
      .wb_stb_o       (wb_stb_o),
      .wb_we_o        (wb_we_o),
      .wb_adr_o       (wb_adr_o),
      .wb_dat_o       (wb_dat_o),
      .wb_ack_i       (wb_ack_i),
      .retire_valid_o (retire_valid_o),
      .retire_rd_o    (retire_rd_o),
      .retire_data_o  (retire_data_o),
      .error_count_o  (checker_errors),
      .pending_o      (pending),
      .retire_count_o (retired)
   );

   function automatic word_t r_type(input logic alt, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input opcode_t opc);
      return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input opcode_t opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input opcode_t opc);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
   endfunction

   function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                    input opcode_t opc);
      return {imm, rd, opc};
   endfunction

   // Registers come from x0..x7 so that dependent instructions are frequent.
   function automatic word_t random_insn();
      int          kind;
      reg_addr_t   rd;
      reg_addr_t   rs1;
      reg_addr_t   rs2;
      logic [2:0]  f3;
      logic [11:0] imm;
      logic        alt;
      kind = int'($urandom % 12);
      rd   = reg_addr_t'($urandom % 8);
      rs1  = reg_addr_t'($urandom % 8);
      rs2  = reg_addr_t'($urandom % 8);
      f3   = 3'($urandom % 8);
      imm  = 12'($urandom);
      alt  = 1'($urandom % 2);
      if (kind < 4) begin
         return r_type(alt && (f3 == 3'b000 || f3 == 3'b101), rs2, rs1, f3, rd, OPC_OP);
      end
      if (kind < 7) begin
         if (f3 == 3'b001) begin
            imm[11:5] = 7'b0000000;
         end else if (f3 == 3'b101) begin
            imm[11:5] = {1'b0, alt, 5'b00000};
         end
         return i_type(imm, rs1, f3, rd, OPC_OP_IMM);
      end
      if (kind == 7) begin
         return u_type(20'($urandom), rd, OPC_LUI);
      end
      if (kind == 8) begin
         return u_type(20'($urandom), rd, OPC_AUIPC);
      end
      // Half of the accesses stay in the first eight words so loads meet earlier stores.
      imm = ($urandom % 2 == 0) ? 12'(($urandom % 8) * 4) : 12'(($urandom % 256) * 4);
      if (kind == 9) begin
         return i_type(imm, 5'd0, 3'b010, rd, OPC_LOAD);
      end
      return s_type(imm, rs2, 5'd0, 3'b010, OPC_STORE);
   endfunction

   task automatic send_insn(input word_t insn);
      int idle;
      int waited;
      idle = int'($urandom % 3);
      if (idle > 0) begin
         insn_valid_i <= 1'b0;
         repeat (idle) @(posedge clk);
      end
      insn_i       <= insn;
      insn_valid_i <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!insn_ready_o && waited < READY_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!insn_ready_o) begin
         $display("ERROR: insn_ready_o stayed low for %0d cycles", READY_TIMEOUT);
         ready_timeout = 1'b1;
      end
      @(posedge clk);
   endtask

   // Word memory that answers each access after 0 to 3 wait cycles.
   always @(posedge clk) begin : wishbone_memory
      int draw;
      if (reset) begin
         for (int i = 0; i < 256; i++) begin
            mem[i] <= '0;
         end
         wb_ack_i   <= 1'b0;
         mem_active <= 1'b0;
         mem_delay  <= 0;
      end else begin
         wb_ack_i <= 1'b0;
         if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
            draw = mem_active ? mem_delay : int'($urandom % 4);
            if (draw == 0) begin
               wb_ack_i   <= 1'b1;
               mem_active <= 1'b0;
               if (wb_we_o) begin
                  mem[wb_adr_o[7:0]] <= wb_dat_o;
               end else begin
                  wb_dat_i <= mem[wb_adr_o[7:0]];
               end
            end else begin
               mem_active <= 1'b1;
               mem_delay  <= draw - 1;
            end
         end
      end
   end

   always @(posedge clk) begin
      if (reset || !wb_cyc_o) begin
         bus_cycles <= 0;
      end else begin
         bus_cycles <= bus_cycles + 1;
         if (bus_cycles == BUS_TIMEOUT && !bus_timeout) begin
            $display("ERROR: wb_cyc_o held for %0d cycles without finishing", BUS_TIMEOUT);
            bus_timeout <= 1'b1;
         end
      end
   end

   initial begin
      int waited;
      void'($urandom(32'h34115ba4));
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < NUM_INSNS && !ready_timeout && !bus_timeout; i++) begin
         send_insn(random_insn());
      end
      insn_valid_i <= 1'b0;
      waited = 0;
      while (pending != 0 && waited < DRAIN_TIMEOUT && !bus_timeout) begin
         @(posedge clk);
         waited++;
      end
      if (pending != 0) begin
         $display("ERROR: %0d retires or bus writes never arrived", pending);
      end
      $display("Summary: %0d checker errors, %0d assertion failures, %0d missing, %0d retired",
               checker_errors, rv_core_top_inst.rv_core_sva_inst.fail_count, pending, retired);
      if (checker_errors == 0 && pending == 0 && !ready_timeout && !bus_timeout &&
          rv_core_top_inst.rv_core_sva_inst.fail_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: rv_core.f
+incdir+include
hdl/rv_core_pkg.sv
hdl/rv_stage_if.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core_top.sv
testbench/rv_core_sva.sv
testbench/rv_core_checker.sv
testbench/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module rv_core_tb \
   -f rv_core.f --Mdir obj_dir -o rv_core_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/rv_core_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -q '^TEST RESULT: PASS$'; then
   exit 0
fi
exit 1
